/* Bender.yml */
package:
  name: outputChannel

sources:
  # Package first, then leaf modules, then the top level
  - rtl/routerPkg.sv
  - rtl/grantTimer.sv
  - rtl/portArbiter.sv
  - rtl/flitSwitch.sv
  - rtl/outputChannel.sv

  # Testbench, top module outputChannelTb
  - target: test
    files:
      - dv/outputChannelTb.sv

/* dv/outputChannelTb.sv */
module outputChannelTb;

  import routerPkg::*;

  localparam int ClkPeriod   = 8;
  localparam int ResetCycles = 10;
  localparam int NumCycles   = 4000;
  localparam int InputDelay  = 1;
  localparam int Seed        = 2422;

  logic                clk;
  logic                rst;
  flitT                inFlit [NumPorts];
  logic [NumPorts-1:0] req;
  grantT               grant;
  flitT                outFlit;
  logic                outValid;
  logic [NumPorts-1:0] grantVec;

  // Reference model state
  logic [LenWidth-1:0] mLimit [NumPorts];
  logic [LenWidth-1:0] mCount [NumPorts];
  logic [NumPorts-1:0] mState;     // One-hot holder, zero when idle
  logic                mValid;
  flitT                mFlit;
  logic                mFlitKnown; // Output register holds a defined flit

  // Stimulus bookkeeping per port
  int burstLeft [NumPorts]; // Flits still to send after the current one
  int gapLeft   [NumPorts]; // Idle cycles before the next burst

  int grantCount;
  int expiryCount;
  int dropCount;
  int wrapCount;

  assign grantVec = grant;

  outputChannel i_dut
  (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .req      (req),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  task automatic stopWithFailure(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  // ********************
  // Stimulus
  // ********************

  task automatic driveInputs();
    headerT hdr;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (gapLeft[p] > 0)
      begin
        gapLeft[p]--;
        req[p]                 = 1'b0;
        inFlit[p].flitId       = 3'b000; // No flit on the link
        inFlit[p].payload.data = 16'($urandom);
      end
      else if (burstLeft[p] == 0)
      begin
        hdr.dest                 = 4'($urandom);
        hdr.length               = LenWidth'($urandom_range(0, 15));
        inFlit[p].flitId         = FlitHead;
        inFlit[p].payload.header = hdr;
        req[p]                   = 1'b1;
        burstLeft[p]             = $urandom_range(1, 11);
      end
      else
      begin
        burstLeft[p]--;
        inFlit[p].flitId       = (burstLeft[p] == 0) ? FlitTail : FlitBody;
        inFlit[p].payload.data = 16'($urandom);
        req[p]                 = 1'b1;
        if ((burstLeft[p] == 0) && ($urandom_range(0, 2) == 0))
        begin
          gapLeft[p] = $urandom_range(1, 8); // Occasional pause after a tail
        end
      end
    end
  endtask

  // ********************
  // Reference model
  // ********************

  // Advances the model by one clock edge using the inputs now on the pins
  task automatic stepModel();
    logic [NumPorts-1:0] nextState;
    int                  holderIdx;
    int                  p;
    int                  tries;
    logic                keep;
    holderIdx = -1;
    for (int i = 0; i < NumPorts; i++)
    begin
      if (mState[i])
      begin
        holderIdx = i;
      end
    end

    keep = (holderIdx >= 0) && req[holderIdx] && (mCount[holderIdx] != mLimit[holderIdx]);

    if (holderIdx >= 0 && !req[holderIdx] && (mCount[holderIdx] != mLimit[holderIdx]))
    begin
      dropCount++;
    end
    if (holderIdx >= 0 && req[holderIdx] && (mCount[holderIdx] == mLimit[holderIdx]))
    begin
      expiryCount++;
    end

    nextState = '0;
    if (keep)
    begin
      nextState = mState;
    end
    else
    begin
      p     = (holderIdx < 0) ? 0 : (holderIdx + 1) % NumPorts;
      tries = (holderIdx < 0) ? NumPorts : NumPorts - 1; // The holder itself is skipped
      while ((tries > 0) && (nextState == '0))
      begin
        if (req[p])
        begin
          nextState[p] = 1'b1;
        end
        p = (p + 1) % NumPorts;
        tries--;
      end
    end

    if (nextState != '0 && nextState != mState)
    begin
      grantCount++;
      if (holderIdx == int'(PortSouth) && !nextState[PortSouth])
      begin
        wrapCount++;
      end
    end

    // Output link sees the holder's flit only while it still requests
    if (holderIdx >= 0 && req[holderIdx])
    begin
      mFlit      = inFlit[holderIdx];
      mFlitKnown = 1'b1;
      mValid     = 1'b1;
    end
    else
    begin
      mValid = 1'b0;
    end

    for (int i = 0; i < NumPorts; i++)
    begin
      mCount[i] = (keep && (i == holderIdx)) ? mCount[i] + 1'b1 : '0;
      if (inFlit[i].flitId == FlitHead)
      begin
        mLimit[i] = inFlit[i].payload.header.length; // Loaded even without the grant
      end
    end

    mState = nextState;
  endtask

  // ********************
  // Checks
  // ********************

  task automatic checkOutputs();
    assert (grantVec === mState)
    else stopWithFailure($sformatf("Mismatch at time %0t: grant is %b, expected %b",
                                   $time, grantVec, mState));
    assert (outValid === mValid)
    else stopWithFailure($sformatf("Mismatch at time %0t: outValid is %b, expected %b",
                                   $time, outValid, mValid));
    if (mFlitKnown)
    begin
      assert (outFlit.flitId === mFlit.flitId)
      else stopWithFailure($sformatf("Mismatch at time %0t: flitId is %b, expected %b",
                                     $time, outFlit.flitId, mFlit.flitId));
      if (mFlit.flitId == FlitHead)
      begin
        assert (outFlit.payload.header.dest === mFlit.payload.header.dest)
        else stopWithFailure($sformatf("Mismatch at time %0t: dest is %h, expected %h",
                                       $time, outFlit.payload.header.dest,
                                       mFlit.payload.header.dest));
        assert (outFlit.payload.header.length === mFlit.payload.header.length)
        else stopWithFailure($sformatf("Mismatch at time %0t: length is %0d, expected %0d",
                                       $time, outFlit.payload.header.length,
                                       mFlit.payload.header.length));
      end
      assert (outFlit.payload.data === mFlit.payload.data)
      else stopWithFailure($sformatf("Mismatch at time %0t: payload is %h, expected %h",
                                     $time, outFlit.payload.data, mFlit.payload.data));
    end
  endtask

  // Every arbitration case must have occurred at least once
  task automatic checkCoverage();
    assert (grantCount > 0)
    else stopWithFailure("The stimulus never moved the grant to a new port");
    assert (expiryCount > 0)
    else stopWithFailure("No holder ever reached its grant limit while requesting");
    assert (dropCount > 0)
    else stopWithFailure("No holder ever dropped its request before its limit");
    assert (wrapCount > 0)
    else stopWithFailure("The grant never rotated onward from South");
  endtask

  initial
  begin
    void'($urandom(Seed));
    rst = 1'b1;
    req = '0;
    for (int p = 0; p < NumPorts; p++)
    begin
      inFlit[p]    = '0;
      mLimit[p]    = '0;
      mCount[p]    = '0;
      burstLeft[p] = 0;
      gapLeft[p]   = $urandom_range(0, 6); // Staggered first requests
    end
    mState      = '0;
    mValid      = 1'b0;
    mFlit       = '0;
    mFlitKnown  = 1'b0;
    grantCount  = 0;
    expiryCount = 0;
    dropCount   = 0;
    wrapCount   = 0;

    repeat (ResetCycles) @(posedge clk);
    #InputDelay;
    rst = 1'b0;
    checkOutputs(); // Idle grant and low valid straight out of reset
    driveInputs();
    stepModel();

    for (int c = 0; c < NumCycles; c++)
    begin
      @(posedge clk);
      #InputDelay;
      checkOutputs();
      driveInputs();
      stepModel();
    end
    @(posedge clk);
    #InputDelay;
    checkOutputs();

    $display("Grants %0d, limit expiries %0d, early drops %0d, wraps from South %0d",
             grantCount, expiryCount, dropCount, wrapCount);
    checkCoverage();
    $display("SIMULATION PASSED");
    $finish;
  end

  // Watchdog sized from the reset and stimulus lengths
  initial
  begin
    #((ResetCycles + NumCycles + 20) * ClkPeriod);
    stopWithFailure("Timeout: the test did not finish in the expected number of cycles");
  end

endmodule

/* outputChannel.f */
rtl/routerPkg.sv
rtl/grantTimer.sv
rtl/portArbiter.sv
rtl/flitSwitch.sv
rtl/outputChannel.sv
dv/outputChannelTb.sv

/* rtl/flitSwitch.sv */
module flitSwitch
(
  input  logic                           clk,
  input  logic                           rst,
  input  routerPkg::grantT               grant,
  input  logic [routerPkg::NumPorts-1:0] req,
  input  routerPkg::flitT                inFlit [routerPkg::NumPorts],
  output routerPkg::flitT                outFlit,
  output logic                           outValid
);

  import routerPkg::*;

  logic [NumPorts-1:0] grantVec;
  flitT                selFlit;  // Flit of the granted port
  logic                selValid; // Granted port is still requesting

  assign grantVec = grant;

  // ********************
  // One-hot select
  // ********************

  // The grant is one-hot or zero, so an AND-OR tree is enough
  always_comb
  begin
    selFlit  = '0;
    selValid = 1'b0;
    for (int i = 0; i < NumPorts; i++)
    begin
      if (grantVec[i])
      begin
        selFlit  = selFlit | inFlit[i];
        selValid = selValid | req[i];
      end
    end
  end

  // ********************
  // Output link register
  // ********************

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= selValid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (selValid)
    begin
      outFlit <= selFlit; // Holds the last flit while the link is idle
    end
  end

endmodule

/* rtl/grantTimer.sv */
module grantTimer
(
  input  logic            clk,
  input  logic            rst,
  input  routerPkg::flitT inFlit,
  input  logic            run,
  output logic            timesUp
);

  import routerPkg::*;

  logic [LenWidth-1:0] limit; // Length of the latest head flit on this port
  logic [LenWidth-1:0] count; // Cycles the port has held the channel

  // ********************
  // Limit and counter
  // ********************

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // Head flits update the limit whether or not the port holds the grant
      if (inFlit.flitId == FlitHead)
      begin
        limit <= inFlit.payload.header.length;
      end

      if (run)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0; // Each new grant period starts from zero
      end
    end
  end

  assign timesUp = (count == limit);

endmodule

/* rtl/outputChannel.sv */
module outputChannel
(
  input  logic                           clk,
  input  logic                           rst,
  input  routerPkg::flitT                inFlit [routerPkg::NumPorts],
  input  logic [routerPkg::NumPorts-1:0] req,
  output routerPkg::grantT               grant,
  output routerPkg::flitT                outFlit,
  output logic                           outValid
);

  import routerPkg::*;

  logic [NumPorts-1:0] timesUp; // Per-port grant limit reached
  logic [NumPorts-1:0] run;     // Per-port timer enable from the arbiter

  // ********************
  // Grant timers
  // ********************

  for (genvar p = 0; p < NumPorts; p++)
  begin : genTimer
    grantTimer uTimer
    (
      .clk     (clk),
      .rst     (rst),
      .inFlit  (inFlit[p]),
      .run     (run[p]),
      .timesUp (timesUp[p])
    );
  end

  // ********************
  // Arbiter and switch
  // ********************

  portArbiter uArbiter
  (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .timesUp (timesUp),
    .grant   (grant),
    .run     (run)
  );

  flitSwitch uSwitch
  (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .req      (req),
    .inFlit   (inFlit),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

/* rtl/portArbiter.sv */
module portArbiter
(
  input  logic                           clk,
  input  logic                           rst,
  input  logic [routerPkg::NumPorts-1:0] req,
  input  logic [routerPkg::NumPorts-1:0] timesUp,
  output routerPkg::grantT               grant,
  output logic [routerPkg::NumPorts-1:0] run
);

  import routerPkg::*;

  logic [NumPorts-1:0] curVec;  // Current state as a plain vector
  logic [NumPorts-1:0] nextVec; // Next state
  logic [NumPorts-1:0] keepVec; // Holder that keeps the channel this cycle
  portIdxE             holder;  // Index of the current holder
  logic                idle;
  int                  searchStart;
  int                  searchSpan;

  // First requester among span ports, starting at start and wrapping after South
  function automatic logic [NumPorts-1:0] firstReq
  (
    input logic [NumPorts-1:0] reqVec,
    input int                  start,
    input int                  span
  );
    logic [NumPorts-1:0] pick;
    int                  idx;
    pick = '0;
    // Walk backwards so the earliest port in rotation overwrites later ones
    for (int k = NumPorts - 1; k >= 0; k--)
    begin
      idx = start + k;
      if (idx >= NumPorts)
      begin
        idx = idx - NumPorts;
      end
      if ((k < span) && reqVec[idx])
      begin
        pick = '0;
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  assign curVec = grant;
  assign idle   = (curVec == '0);

  // ********************
  // Holder decode
  // ********************

  always_comb
  begin
    holder = PortLocal;
    for (int i = 0; i < NumPorts; i++)
    begin
      if (curVec[i])
      begin
        holder = portIdxE'(i);
      end
    end
  end

  // Only the holder can keep the channel, and only before its time is up
  assign keepVec = curVec & req & ~timesUp;
  assign run     = keepVec;

  // ********************
  // Next state
  // ********************

  always_comb
  begin
    if (idle)
    begin
      searchStart = int'(PortLocal); // Fixed order Local, North, East, West, South
      searchSpan  = NumPorts;
    end
    else
    begin
      searchStart = int'(holder) + 1; // Rotate past the holder and skip it
      searchSpan  = NumPorts - 1;
    end
  end

  always_comb
  begin
    if (keepVec != '0)
    begin
      nextVec = curVec;
    end
    else
    begin
      nextVec = firstReq(req, searchStart, searchSpan); // All zero means idle
    end
  end

  // ********************
  // State register
  // ********************

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= '0;
    end
    else
    begin
      grant <= nextVec;
    end
  end

endmodule

/* rtl/routerPkg.sv */
package routerPkg;

  // ********************
  // Port order
  // ********************

  localparam int NumPorts = 5;

  typedef enum logic [2:0]
  {
    PortLocal = 3'd0,
    PortNorth = 3'd1,
    PortEast  = 3'd2,
    PortWest  = 3'd3,
    PortSouth = 3'd4
  } portIdxE;

  // ********************
  // Flit format
  // ********************

  localparam logic [2:0] FlitHead = 3'b001;
  localparam logic [2:0] FlitBody = 3'b010;
  localparam logic [2:0] FlitTail = 3'b100;

  localparam int LenWidth = 12;

  typedef struct packed
  {
    logic [3:0]          dest;   // Destination router
    logic [LenWidth-1:0] length; // Grant limit in cycles, minus one
  } headerT;

  // A head flit carries the header view, body and tail flits carry raw data
  typedef union packed
  {
    headerT                      header;
    logic [$bits(headerT)-1:0]   data;
  } payloadU;

  typedef struct packed
  {
    logic [2:0] flitId;
    payloadU    payload;
  } flitT;

  // ********************
  // Grant vector
  // ********************

  // Declared South first so that bit i belongs to port i of portIdxE
  typedef struct packed
  {
    logic south;
    logic west;
    logic east;
    logic north;
    logic loc;
  } grantT;

endpackage
